// File: alu_top.f
+incdir+hw
hw/alu_pkg.sv
hw/alu_arith_if.sv
hw/alu_adder.sv
hw/alu_shifter.sv
hw/alu_bitcount.sv
hw/alu_result_mux.sv
hw/alu_top.sv
tests/alu_checker.sv
tests/alu_tb.sv

// File: Bender.yml
package:
  name: alu_top

sources:
  - include_dirs:
      - hw
    files:
      - hw/alu_pkg.sv
      - hw/alu_arith_if.sv
      - hw/alu_adder.sv
      - hw/alu_shifter.sv
      - hw/alu_bitcount.sv
      - hw/alu_result_mux.sv
      - hw/alu_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tests/alu_checker.sv
      - tests/alu_tb.sv

// File: tests/alu_trace.txt
# Columns, all hex: operation code, operand a, operand b, expected result, expected branch bit
# Codes follow alu_op_e in alu_pkg; lines run back to back, one per cycle
00 00000005 00000003 00000008 1
00 ffffffff 00000001 00000000 1
01 00000003 00000005 fffffffe 1
02 f0f0ff00 0ff0f0f0 00f0f000 1
03 f0f0ff00 0ff0f0f0 fff0fff0 1
04 f0f0ff00 0ff0f0f0 ff000ff0 1
08 ffffffff 00000001 00000001 1
09 ffffffff 00000001 00000000 1
0a 12345678 12345678 00000000 1
0a 12345678 12345679 00000000 0
0b 12345678 12345679 00000000 1
0c ffffffff 00000001 00000000 1
0d ffffffff 00000001 00000000 0
0e ffffffff 00000001 00000000 0
0f ffffffff 00000001 00000000 1
0c 80000000 7fffffff 00000000 1
10 00000003 00000010 00000016 1
11 00000003 00000010 0000001c 1
12 40000001 00000002 0000000a 1
13 f0f0ff00 0ff0f0f0 f0000f00 1
14 f0f0ff00 0ff0f0f0 f0ffff0f 1
15 f0f0ff00 0ff0f0f0 00fff00f 1
05 00000001 0000001f 80000000 1
05 12345678 00000024 23456780 1
06 80000000 00000001 40000000 1
06 80000000 0000003f 00000001 1
06 12345678 00000000 12345678 1
07 80000000 00000001 c0000000 1
07 80000000 0000001f ffffffff 1
20 80000001 00000001 00000003 1
20 12345678 00000000 12345678 1
21 80000001 00000001 c0000000 1
21 12345678 00000028 78123456 1
1a 00000000 00000000 00000020 1
1a 00010000 00000000 0000000f 1
1b 00000000 00000000 00000020 1
1b 00010000 00000000 00000010 1
1c ffffffff 00000000 00000020 1
1c 12345678 00000000 0000000d 1
22 00100080 00000000 00ff00ff 1
23 12345678 00000000 78563412 1
1d 00000080 00000000 ffffff80 1
1e 00018000 00000000 ffff8000 1
1f ffff8001 00000000 00008001 1
16 ffffffff 00000001 ffffffff 1
17 ffffffff 00000001 00000001 1
18 ffffffff 00000001 00000001 1
19 ffffffff 00000001 ffffffff 1
24 ffffffff 00000024 ffffffef 1
25 80000000 0000001f 00000001 1
26 00000000 0000001f 80000000 1
27 00000000 00000020 00000001 1
28 12345678 00000000 00000000 1
28 12345678 00000100 12345678 1
29 12345678 00000000 12345678 1
29 12345678 00000100 00000000 1

// File: tests/alu_tb.sv
// --------------------
// Testbench of the ALU. Replays the operation trace through the DUT,
// one operation per cycle, and checks each result one cycle later.
// --------------------

`timescale 1ns/1ns

`include "alu_params.svh"

module alu_tb
  import alu_pkg::*;
();

  localparam int    ResetCycles = 16;
  localparam int    Margin      = 20;
  localparam string TraceFile   = "tests/alu_trace.txt";

  logic    clk;
  logic    rst_n;
  alu_op_e operation;
  xlen_t   operand_a;
  xlen_t   operand_b;
  xlen_t   result;
  logic    branch_res;

  alu_op_e trace_op[$];
  xlen_t   trace_a[$];
  xlen_t   trace_b[$];
  xlen_t   trace_res[$];
  logic    trace_br[$];

  int checks       = 0;
  int mismatches   = 0;
  int other_errors = 0;
  int cycle_cnt    = 0;
  int cycle_limit  = 0;

  alu_top dut0 (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .operation_i  (operation),
    .operand_a_i  (operand_a),
    .operand_b_i  (operand_b),
    .result_o     (result),
    .branch_res_o (branch_res)
  );

  bind alu_top alu_checker i_checker (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .operation_i  (operation_i),
    .result_i     (result_o),
    .branch_res_i (branch_res_o)
  );

  // 20 ns period
  initial begin
    clk = 1'b0;
    forever begin
      #10 clk = ~clk;
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      $display("Timeout after %0d cycles, the trace did not complete", cycle_cnt);
      $display("Simulation failed");
      $finish;
    end
  end

  task automatic read_trace();
    int                   fd;
    int                   line_no;
    int                   fields;
    string                line;
    logic [`ALU_OP_W-1:0] code;
    xlen_t                a;
    xlen_t                b;
    xlen_t                res;
    logic                 br;
    fd = $fopen(TraceFile, "r");
    assert (fd != 0) else begin
      $display("Could not open the trace file %s", TraceFile);
      other_errors++;
    end
    if (fd == 0) begin
      return;
    end
    line_no = 0;
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      line_no++;
      // Blank and comment lines
      if (line.len() < 2 || line.substr(0, 0) == "#") begin
        continue;
      end
      fields = $sscanf(line, "%h %h %h %h %h", code, a, b, res, br);
      assert (fields == 5) else begin
        $display("Trace line %0d is incomplete, %0d of 5 fields read", line_no, fields);
        other_errors++;
      end
      if (fields == 5) begin
        trace_op.push_back(alu_op_e'(code));
        trace_a.push_back(a);
        trace_b.push_back(b);
        trace_res.push_back(res);
        trace_br.push_back(br);
      end
    end
    $fclose(fd);
    assert (trace_op.size() > 0) else begin
      $display("The trace file holds no operations");
      other_errors++;
    end
  endtask

  task automatic check_reset_state();
    checks++;
    assert (result === '0) else begin
      $display("Mismatch result_o in reset: expected %h, actual %h", xlen_t'(0), result);
      mismatches++;
    end
    assert (branch_res === 1'b0) else begin
      $display("Mismatch branch_res_o in reset: expected %h, actual %h", 1'b0, branch_res);
      mismatches++;
    end
  endtask

  task automatic drive_operation(int idx);
    operation = trace_op[idx];
    operand_a = trace_a[idx];
    operand_b = trace_b[idx];
  endtask

  task automatic check_outputs(int idx);
    checks++;
    assert (result === trace_res[idx]) else begin
      $display("Mismatch result_o, op %0d (%s): expected %h, actual %h",
               idx, trace_op[idx].name(), trace_res[idx], result);
      mismatches++;
    end
    assert (branch_res === trace_br[idx]) else begin
      $display("Mismatch branch_res_o, op %0d (%s): expected %h, actual %h",
               idx, trace_op[idx].name(), trace_br[idx], branch_res);
      mismatches++;
    end
  endtask

  initial begin
    rst_n     = 1'b0;
    operation = ADD;
    operand_a = '0;
    operand_b = '0;
    read_trace();
    cycle_limit = ResetCycles + trace_op.size() + Margin;
    repeat (ResetCycles) begin
      @(posedge clk);
      #2;
      check_reset_state();
    end
    // Released with no edge seen yet
    rst_n = 1'b1;
    check_reset_state();
    // Next op goes in as the previous result is checked
    for (int i = 0; i < trace_op.size(); i++) begin
      drive_operation(i);
      @(posedge clk);
      #2;
      check_outputs(i);
    end
    // One more edge so the checker sees the last result
    @(posedge clk);
    #2;
    $display("Checks: %0d, mismatches: %0d, other errors: %0d, assertion failures: %0d",
             checks, mismatches, other_errors, dut0.i_checker.fail_count);
    if (mismatches == 0 && other_errors == 0 && dut0.i_checker.fail_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: tests/alu_checker.sv
// --------------------
// Concurrent assertions on the ALU outputs.
// Bound into alu_top from the testbench.
// --------------------

`timescale 1ns/1ns

`include "alu_params.svh"

module alu_checker
  import alu_pkg::*;
(
  input logic    clk_i,
  input logic    rst_n_i,
  input alu_op_e operation_i,
  input xlen_t   result_i,
  input logic    branch_res_i
);

  logic is_compare;

  // Count of failed assertions for the final verdict
  int fail_count = 0;

  assign is_compare = operation_i inside {EQ, NE, LTS, LTU, GES, GEU};

  // Output register held clear in reset
  reset_outputs_zero: assert property (
    @(posedge clk_i) !rst_n_i |-> (result_i == '0 && !branch_res_i)
  ) else begin
    fail_count++;
    $error("ALU outputs are not zero while reset is asserted");
  end

  // Non-compare ops always report taken
  branch_default_taken: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) !is_compare |=> branch_res_i
  ) else begin
    fail_count++;
    $error("Branch bit is low after an operation that is not a compare");
  end

  cpop_in_range: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) (operation_i == CPOP) |=> (result_i <= `ALU_XLEN)
  ) else begin
    fail_count++;
    $error("CPOP produced a count above the datapath width");
  end

endmodule

// File: hw/alu_top.sv
// --------------------
// 32-bit RISC-V integer ALU with a registered output.
// One operation per cycle, result one cycle after its inputs.
// --------------------

`timescale 1ns/1ns

`include "alu_params.svh"

module alu_top
  import alu_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_n_i,
  input  alu_op_e operation_i,
  input  xlen_t   operand_a_i,
  input  xlen_t   operand_b_i,
  output xlen_t   result_o,
  output logic    branch_res_o
);

  xlen_t shift_result;
  cnt_t  clz_count;
  cnt_t  ctz_count;
  cnt_t  pop_count;
  xlen_t orcb_result;
  xlen_t rev8_result;

  alu_arith_if arith_if ();

  alu_adder i_adder (
    .operation_i (operation_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .arith       (arith_if.src)
  );

  // Only the low bits of b select the amount
  alu_shifter i_shifter (
    .operation_i    (operation_i),
    .operand_a_i    (operand_a_i),
    .shamt_i        (operand_b_i[`ALU_SHAMT_W-1:0]),
    .shift_result_o (shift_result)
  );

  alu_bitcount i_bitcount (
    .operand_a_i   (operand_a_i),
    .clz_count_o   (clz_count),
    .ctz_count_o   (ctz_count),
    .pop_count_o   (pop_count),
    .orcb_result_o (orcb_result),
    .rev8_result_o (rev8_result)
  );

  alu_result_mux i_result_mux (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .operation_i    (operation_i),
    .operand_a_i    (operand_a_i),
    .operand_b_i    (operand_b_i),
    .arith          (arith_if.snk),
    .shift_result_i (shift_result),
    .clz_count_i    (clz_count),
    .ctz_count_i    (ctz_count),
    .pop_count_i    (pop_count),
    .orcb_result_i  (orcb_result),
    .rev8_result_i  (rev8_result),
    .result_o       (result_o),
    .branch_res_o   (branch_res_o)
  );

endmodule

// File: hw/alu_result_mux.sv
// --------------------
// Result select and branch resolve, both registered once.
// Outputs follow the inputs by one clock cycle.
// --------------------

`timescale 1ns/1ns

`include "alu_params.svh"

module alu_result_mux
  import alu_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_n_i,
  input  alu_op_e operation_i,
  input  xlen_t   operand_a_i,
  input  xlen_t   operand_b_i,
  alu_arith_if.snk arith,
  input  xlen_t   shift_result_i,
  input  cnt_t    clz_count_i,
  input  cnt_t    ctz_count_i,
  input  cnt_t    pop_count_i,
  input  xlen_t   orcb_result_i,
  input  xlen_t   rev8_result_i,
  output xlen_t   result_o,
  output logic    branch_res_o
);

  localparam int CntPad = `ALU_XLEN - `ALU_CNT_W;

  shamt_t bit_idx;
  xlen_t  bit_mask;
  xlen_t  result_d;
  logic   branch_d;

  // One-hot mask for the Zbs ops
  assign bit_idx  = operand_b_i[`ALU_SHAMT_W-1:0];
  assign bit_mask = xlen_t'(1) << bit_idx;

  // --------------------
  // Result select
  // --------------------
  always_comb begin
    case (operation_i)
      ANDL, ANDN: result_d = operand_a_i & arith.operand_b_neg;
      ORL, ORN:   result_d = operand_a_i | arith.operand_b_neg;
      XORL, XNOR: result_d = operand_a_i ^ arith.operand_b_neg;
      ADD, SUB, SH1ADD, SH2ADD, SH3ADD: begin
        result_d = arith.adder_result;
      end
      SLL, SRL, SRA, ROL, ROR: result_d = shift_result_i;
      SLTS, SLTU: result_d = {{(`ALU_XLEN - 1){1'b0}}, arith.less};
      // Min/max pick by the comparator
      MIN, MINU:  result_d = arith.less ? operand_a_i : operand_b_i;
      MAX, MAXU:  result_d = arith.less ? operand_b_i : operand_a_i;
      CLZ:        result_d = {{CntPad{1'b0}}, clz_count_i};
      CTZ:        result_d = {{CntPad{1'b0}}, ctz_count_i};
      CPOP:       result_d = {{CntPad{1'b0}}, pop_count_i};
      ORCB:       result_d = orcb_result_i;
      REV8:       result_d = rev8_result_i;
      SEXTB:      result_d = {{(`ALU_XLEN - 8){operand_a_i[7]}}, operand_a_i[7:0]};
      SEXTH:      result_d = {{(`ALU_XLEN - 16){operand_a_i[15]}}, operand_a_i[15:0]};
      ZEXTH:      result_d = {{(`ALU_XLEN - 16){1'b0}}, operand_a_i[15:0]};
      BCLR:       result_d = operand_a_i & ~bit_mask;
      BEXT:       result_d = {{(`ALU_XLEN - 1){1'b0}}, |(operand_a_i & bit_mask)};
      BINV:       result_d = operand_a_i ^ bit_mask;
      BSET:       result_d = operand_a_i | bit_mask;
      // Zicond, zero when the condition in b holds
      CZERO_EQZ:  result_d = (|operand_b_i) ? operand_a_i : '0;
      CZERO_NEZ:  result_d = (|operand_b_i) ? '0 : operand_a_i;
      default:    result_d = '0;
    endcase
  end

  // --------------------
  // Branch resolve
  // --------------------
  // Non-compare ops report taken
  always_comb begin
    case (operation_i)
      EQ:       branch_d = arith.zero;
      NE:       branch_d = ~arith.zero;
      LTS, LTU: branch_d = arith.less;
      GES, GEU: branch_d = ~arith.less;
      default:  branch_d = 1'b1;
    endcase
  end

  // Output register
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      result_o     <= '0;
      branch_res_o <= 1'b0;
    end else begin
      result_o     <= result_d;
      branch_res_o <= branch_d;
    end
  end

endmodule

// File: hw/alu_bitcount.sv
// --------------------
// Bit counting and byte operations on operand a.
// Zero counts give 32 for an all-zero input.
// --------------------

`timescale 1ns/1ns

`include "alu_params.svh"

module alu_bitcount
  import alu_pkg::*;
(
  input  xlen_t operand_a_i,
  output cnt_t  clz_count_o,
  output cnt_t  ctz_count_o,
  output cnt_t  pop_count_o,
  output xlen_t orcb_result_o,
  output xlen_t rev8_result_o
);

  // --------------------
  // Zero counts
  // --------------------
  // Highest set bit wins, scanning upward
  always_comb begin
    clz_count_o = cnt_t'(`ALU_XLEN);
    for (int i = 0; i < `ALU_XLEN; i++) begin
      if (operand_a_i[i]) begin
        clz_count_o = cnt_t'(`ALU_XLEN - 1 - i);
      end
    end
  end

  // Lowest set bit wins, scanning downward
  always_comb begin
    ctz_count_o = cnt_t'(`ALU_XLEN);
    for (int i = `ALU_XLEN - 1; i >= 0; i--) begin
      if (operand_a_i[i]) begin
        ctz_count_o = cnt_t'(i);
      end
    end
  end

  // Population count
  always_comb begin
    pop_count_o = '0;
    for (int i = 0; i < `ALU_XLEN; i++) begin
      pop_count_o = pop_count_o + cnt_t'(operand_a_i[i]);
    end
  end

  // --------------------
  // Byte operations
  // --------------------
  always_comb begin
    for (int b = 0; b < `ALU_XLEN / 8; b++) begin
      orcb_result_o[8*b +: 8] = {8{|operand_a_i[8*b +: 8]}};
      rev8_result_o[8*b +: 8] = operand_a_i[8*(`ALU_XLEN/8 - 1 - b) +: 8];
    end
  end

endmodule

// File: hw/alu_shifter.sv
// --------------------
// Shifts and rotations of operand a.
// Left shifts reuse the right shifter on the bit-reversed operand.
// --------------------

`timescale 1ns/1ns

`include "alu_params.svh"

module alu_shifter
  import alu_pkg::*;
(
  input  alu_op_e operation_i,
  input  xlen_t   operand_a_i,
  input  shamt_t  shamt_i,
  output xlen_t   shift_result_o
);

  function automatic xlen_t bit_rev(xlen_t value);
    xlen_t rev;
    for (int i = 0; i < `ALU_XLEN; i++) begin
      rev[i] = value[`ALU_XLEN-1-i];
    end
    return rev;
  endfunction

  logic      shift_left;
  logic      shift_arith;
  xlen_ext_t shift_in;
  xlen_ext_t shift_right;
  xlen_t     shift_left_res;
  shamt_t    rot_back;

  assign shift_left  = (operation_i == SLL);
  assign shift_arith = (operation_i == SRA);

  // Sign fill only for SRA
  assign shift_in = {shift_arith & operand_a_i[`ALU_XLEN-1],
                     shift_left ? bit_rev(operand_a_i) : operand_a_i};

  assign shift_right    = xlen_ext_t'($signed(shift_in) >>> shamt_i);
  assign shift_left_res = bit_rev(shift_right[`ALU_XLEN-1:0]);

  // Opposite amount for rotations, wraps to zero when shamt is zero
  assign rot_back = -shamt_i;

  always_comb begin
    case (operation_i)
      SLL:     shift_result_o = shift_left_res;
      ROL:     shift_result_o = (operand_a_i << shamt_i) | (operand_a_i >> rot_back);
      ROR:     shift_result_o = (operand_a_i >> shamt_i) | (operand_a_i << rot_back);
      default: shift_result_o = shift_right[`ALU_XLEN-1:0];
    endcase
  end

endmodule

// File: hw/alu_adder.sv
// --------------------
// Shared adder and comparator of the ALU.
// Combinational; results leave through the arith interface.
// --------------------

`timescale 1ns/1ns

`include "alu_params.svh"

module alu_adder
  import alu_pkg::*;
(
  input  alu_op_e operation_i,
  input  xlen_t   operand_a_i,
  input  xlen_t   operand_b_i,
  alu_arith_if.src arith
);

  logic      negate_b;
  logic      signed_cmp;
  xlen_t     operand_a_sh;
  xlen_ext_t adder_in_a;
  xlen_ext_t adder_in_b;
  xlen_ext_t adder_sum;
  xlen_t     adder_result;

  assign negate_b   = operation_i inside {SUB, EQ, NE, ANDN, ORN, XNOR};
  assign signed_cmp = operation_i inside {SLTS, LTS, GES, MIN, MAX};

  // Pre-shift of operand a for the Zba shift-adds
  always_comb begin
    case (operation_i)
      SH1ADD:  operand_a_sh = operand_a_i << 1;
      SH2ADD:  operand_a_sh = operand_a_i << 2;
      SH3ADD:  operand_a_sh = operand_a_i << 3;
      default: operand_a_sh = operand_a_i;
    endcase
  end

  // --------------------
  // Adder
  // --------------------
  // LSB of a is one, so an inverted b gets its +1 carry at bit 1
  assign adder_in_a   = {operand_a_sh, 1'b1};
  assign adder_in_b   = {operand_b_i, 1'b0} ^ {(`ALU_XLEN + 1){negate_b}};
  assign adder_sum    = adder_in_a + adder_in_b;
  assign adder_result = adder_sum[`ALU_XLEN:1];

  assign arith.adder_result  = adder_result;
  assign arith.operand_b_neg = adder_in_b[`ALU_XLEN:1];
  assign arith.zero          = ~|adder_result;

  // --------------------
  // Comparator
  // --------------------
  // Extra top bit turns the unsigned compare into a signed one
  assign arith.less = $signed({signed_cmp & operand_a_i[`ALU_XLEN-1], operand_a_i}) <
                      $signed({signed_cmp & operand_b_i[`ALU_XLEN-1], operand_b_i});

endmodule

// File: hw/alu_arith_if.sv
// --------------------
// Adder and comparator results, from the adder to the result select.
// Plain levels, valid in the same cycle as the ALU inputs.
// --------------------

`timescale 1ns/1ns

interface alu_arith_if;

  alu_pkg::xlen_t adder_result;
  // Operand b after the optional inversion
  alu_pkg::xlen_t operand_b_neg;
  logic           less;
  logic           zero;

  modport src (
    output adder_result, operand_b_neg, less, zero
  );

  modport snk (
    input adder_result, operand_b_neg, less, zero
  );

endinterface

// File: hw/alu_pkg.sv
// --------------------
// Operation codes and vector types shared by the ALU units.
// The enum values are the codes used in the trace file.
// --------------------

package alu_pkg;

  `include "alu_params.svh"

  typedef logic [`ALU_XLEN-1:0]    xlen_t;
  typedef logic [`ALU_XLEN:0]      xlen_ext_t;
  typedef logic [`ALU_SHAMT_W-1:0] shamt_t;
  typedef logic [`ALU_CNT_W-1:0]   cnt_t;

  typedef enum logic [`ALU_OP_W-1:0] {
    // Base integer
    ADD       = 6'd0,
    SUB       = 6'd1,
    ANDL      = 6'd2,
    ORL       = 6'd3,
    XORL      = 6'd4,
    SLL       = 6'd5,
    SRL       = 6'd6,
    SRA       = 6'd7,
    SLTS      = 6'd8,
    SLTU      = 6'd9,
    // Branch compares
    EQ        = 6'd10,
    NE        = 6'd11,
    LTS       = 6'd12,
    LTU       = 6'd13,
    GES       = 6'd14,
    GEU       = 6'd15,
    // Zba
    SH1ADD    = 6'd16,
    SH2ADD    = 6'd17,
    SH3ADD    = 6'd18,
    // Zbb
    ANDN      = 6'd19,
    ORN       = 6'd20,
    XNOR      = 6'd21,
    MIN       = 6'd22,
    MAX       = 6'd23,
    MINU      = 6'd24,
    MAXU      = 6'd25,
    CLZ       = 6'd26,
    CTZ       = 6'd27,
    CPOP      = 6'd28,
    SEXTB     = 6'd29,
    SEXTH     = 6'd30,
    ZEXTH     = 6'd31,
    ROL       = 6'd32,
    ROR       = 6'd33,
    ORCB      = 6'd34,
    REV8      = 6'd35,
    // Zbs
    BCLR      = 6'd36,
    BEXT      = 6'd37,
    BINV      = 6'd38,
    BSET      = 6'd39,
    // Zicond
    CZERO_EQZ = 6'd40,
    CZERO_NEZ = 6'd41
  } alu_op_e;

endpackage

// File: hw/alu_params.svh
// --------------------
// Width and field-size macros of the ALU datapath.
// Included by the package and by RTL that sizes vectors or loops.
// --------------------

`ifndef ALU_PARAMS_SVH
`define ALU_PARAMS_SVH

// Datapath width
`define ALU_XLEN 32

// Shift, rotate and bit-index amount
`define ALU_SHAMT_W 5

// Count result, wide enough to hold the value 32
`define ALU_CNT_W 6

// Operation code
`define ALU_OP_W 6

`endif
